/* project.f */
source/tlu_pkg.sv
source/tlu_cfg_if.sv
source/tlu_trig_if.sv
source/tlu_register_file.sv
source/trigger_input.sv
source/tlu_handshake_fsm.sv
source/trigger_fifo.sv
source/tlu_controller.sv
testbench/tb_tlu_controller.sv

/* run.sh */
#!/usr/bin/env bash
# build the tlu controller testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tlu_controller -f project.f -o tb_tlu_controller &&
./obj_dir/tb_tlu_controller | tee /dev/stderr | grep -q "^Everything OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* source/tlu_cfg_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu configuration bus
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface tlu_cfg_if import tlu_pkg::*; ();

    tlu_mode_t  mode;
    logic       msb_first;     // trigger data order
    logic [4:0] clock_cycles;  // 0 means 32 bits
    logic       enable_reset;

    modport source (
        output mode, msb_first, clock_cycles, enable_reset
    );

    modport sink (
        input mode, msb_first, clock_cycles, enable_reset
    );

endinterface

/* source/tlu_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu controller top
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tlu_controller import tlu_pkg::*; #(
    parameter int DIVISOR    = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic [ADDR_WIDTH-1:0] BUS_ADD,
    input  logic [DATA_WIDTH-1:0] BUS_DATA_IN,
    input  logic                  BUS_WR,
    output logic [DATA_WIDTH-1:0] BUS_DATA_OUT,
    input  logic                  FIFO_READ,
    output logic                  FIFO_EMPTY,
    output logic [WORD_WIDTH-1:0] FIFO_DATA,
    input  logic                  RJ45_TRIGGER,
    input  logic                  LEMO_TRIGGER,
    input  logic                  RJ45_RESET,
    input  logic                  LEMO_RESET,
    output logic                  RJ45_ENABLED,
    output logic                  TLU_BUSY,
    output logic                  TLU_CLOCK
);

    logic                  soft_rst;
    logic                  rst_int;   // bus reset or soft reset
    logic                  push;
    logic [WORD_WIDTH-1:0] word;
    logic [WORD_WIDTH-1:0] trig_number;
    logic [7:0]            lost_count;

    tlu_cfg_if  cfg_bus ();
    tlu_trig_if trig_bus ();

    assign rst_int = RST | soft_rst;

    tlu_register_file u_register_file (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst_int),
        .bus_add      (BUS_ADD),
        .bus_data_in  (BUS_DATA_IN),
        .bus_wr       (BUS_WR),
        .trig_number  (trig_number),
        .lost_count   (lost_count),
        .bus_data_out (BUS_DATA_OUT),
        .soft_rst     (soft_rst),
        .cfg          (cfg_bus.source)
    );

    trigger_input u_trigger_input (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst_int),
        .rj45_trigger (RJ45_TRIGGER),
        .rj45_reset   (RJ45_RESET),
        .lemo_trigger (LEMO_TRIGGER),
        .lemo_reset   (LEMO_RESET),
        .cfg          (cfg_bus.sink),
        .rj45_enabled (RJ45_ENABLED),
        .trig         (trig_bus.source)
    );

    tlu_handshake_fsm #(
        .DIVISOR (DIVISOR)
    ) u_handshake_fsm (
        .BUS_CLK     (BUS_CLK),
        .RST         (rst_int),
        .cfg         (cfg_bus.sink),
        .trig        (trig_bus.sink),
        .tlu_busy    (TLU_BUSY),
        .tlu_clock   (TLU_CLOCK),
        .push        (push),
        .word        (word),
        .trig_number (trig_number)
    );

    trigger_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_trigger_fifo (
        .BUS_CLK    (BUS_CLK),
        .RST        (rst_int),
        .push       (push),
        .word       (word),
        .read       (FIFO_READ),
        .empty      (FIFO_EMPTY),
        .data       (FIFO_DATA),
        .lost_count (lost_count)
    );

endmodule

/* source/tlu_handshake_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu handshake fsm
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tlu_handshake_fsm import tlu_pkg::*; #(
    parameter int DIVISOR = 16
) (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    tlu_cfg_if.sink               cfg,
    tlu_trig_if.sink              trig,
    output logic                  tlu_busy,
    output logic                  tlu_clock,
    output logic                  push,
    output logic [WORD_WIDTH-1:0] word,
    output logic [WORD_WIDTH-1:0] trig_number
);

    localparam int HALF = DIVISOR / 2;
    localparam int CW   = $clog2(HALF);
    localparam logic [CW-1:0] HALF_LAST = CW'(HALF - 1);

    fsm_state_t            state;
    logic [CW-1:0]         div_cnt;   // cycles within one clock phase
    logic [5:0]            bit_cnt;
    logic [5:0]            n_bits;
    logic [WORD_WIDTH-1:0] shift_q;
    logic [WORD_WIDTH-1:0] counter;
    logic [WORD_WIDTH-1:0] received;
    logic [WORD_WIDTH-1:0] number;

    function automatic logic [WORD_WIDTH-1:0] reverse_bits(input logic [WORD_WIDTH-1:0] v);
        logic [WORD_WIDTH-1:0] r;
        for (int i = 0; i < WORD_WIDTH; i++)
            r[i] = v[WORD_WIDTH-1-i];
        return r;
    endfunction

    assign n_bits = (cfg.clock_cycles == 5'd0) ? 6'd32 : {1'b0, cfg.clock_cycles};

    // shift_q starts cleared, so the reversed upper bits come out zero
    assign received = cfg.msb_first ? reverse_bits(shift_q) : (shift_q >> (6'd32 - n_bits));
    assign number   = (cfg.mode == MODE_DATA_HANDSHAKE) ? received : counter;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state       <= IDLE;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            counter     <= '0;
            trig_number <= '0;
            tlu_busy    <= 1'b0;
            tlu_clock   <= 1'b0;
            push        <= 1'b0;
        end
        else
        begin
            push <= 1'b0;
            case (state)
                IDLE:
                    if (trig.trigger_rise && cfg.mode != MODE_DISABLED)
                    begin
                        if (cfg.mode == MODE_NO_HANDSHAKE)
                            state <= WRITE_WORD;
                        else
                        begin
                            tlu_busy <= 1'b1;
                            state    <= WAIT_LOW;
                        end
                    end
                WAIT_LOW:
                    if (!trig.trigger)
                    begin
                        if (cfg.mode == MODE_DATA_HANDSHAKE)
                        begin
                            div_cnt   <= '0;
                            bit_cnt   <= '0;
                            shift_q   <= '0;
                            tlu_clock <= 1'b1;
                            state     <= CLOCK_HIGH;
                        end
                        else
                            state <= WRITE_WORD;
                    end
                CLOCK_HIGH:
                    if (div_cnt == HALF_LAST)
                    begin
                        div_cnt   <= '0;
                        shift_q   <= {trig.trigger, shift_q[WORD_WIDTH-1:1]};  // sample bit
                        tlu_clock <= 1'b0;
                        state     <= CLOCK_LOW;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                CLOCK_LOW:
                    if (div_cnt == HALF_LAST)
                    begin
                        div_cnt <= '0;
                        if (bit_cnt == n_bits - 6'd1)
                            state <= WRITE_WORD;
                        else
                        begin
                            bit_cnt   <= bit_cnt + 6'd1;
                            tlu_clock <= 1'b1;
                            state     <= CLOCK_HIGH;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                WRITE_WORD:
                begin
                    push        <= 1'b1;
                    word        <= {1'b1, number[TRIG_WORD_FLAG-1:0]};
                    trig_number <= number;
                    counter     <= counter + 1'b1;
                    tlu_busy    <= 1'b0;
                    state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
            if (trig.reset_rise)
                counter <= '0;  // tlu reset wins over the increment
        end
    end

    initial assert (DIVISOR % 2 == 0 && DIVISOR >= 10)
        else $fatal(1, "DIVISOR must be even and at least 10");

    a_clock_only_busy: assert property (@(posedge BUS_CLK) disable iff (RST)
        tlu_clock |-> tlu_busy);

    // tlu must not send a reset while data bits are clocked out
    a_no_reset_clocking: assert property (@(posedge BUS_CLK) disable iff (RST)
        (state inside {CLOCK_HIGH, CLOCK_LOW}) |-> !trig.reset_level);

endmodule

/* source/tlu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu shared types
// ~~~~~~~~~~~~~~~~~~~~

package tlu_pkg;

    typedef enum logic [1:0] {
        MODE_DISABLED         = 2'd0,
        MODE_NO_HANDSHAKE     = 2'd1,
        MODE_SIMPLE_HANDSHAKE = 2'd2,
        MODE_DATA_HANDSHAKE   = 2'd3
    } tlu_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_LOW,
        CLOCK_HIGH,
        CLOCK_LOW,
        WRITE_WORD
    } fsm_state_t;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 8;
    localparam int WORD_WIDTH = 32;

    // register map
    localparam logic [ADDR_WIDTH-1:0] ADDR_CTRL     = 16'd0;  // write: soft reset
    localparam logic [ADDR_WIDTH-1:0] ADDR_MODE     = 16'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_CONF     = 16'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TRIG_NUM = 16'd4;  // 4..7, little endian
    localparam logic [ADDR_WIDTH-1:0] ADDR_LOST     = 16'd12;

    localparam logic [DATA_WIDTH-1:0] VERSION = 8'd1;
    localparam int TRIG_WORD_FLAG = 31;   // always set in fifo words
    localparam int SYNC_STAGES    = 3;

endpackage

/* source/tlu_register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu register file
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tlu_register_file import tlu_pkg::*; (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic [ADDR_WIDTH-1:0] bus_add,
    input  logic [DATA_WIDTH-1:0] bus_data_in,
    input  logic                  bus_wr,
    input  logic [WORD_WIDTH-1:0] trig_number,
    input  logic [7:0]            lost_count,
    output logic [DATA_WIDTH-1:0] bus_data_out,
    output logic                  soft_rst,
    tlu_cfg_if.source             cfg
);

    tlu_mode_t             mode_q;
    logic                  msb_first_q;
    logic [4:0]            clock_cycles_q;
    logic                  enable_reset_q;
    logic [WORD_WIDTH-1:8] trig_num_buf;  // snapshot for bytes 5..7

    assign cfg.mode         = mode_q;
    assign cfg.msb_first    = msb_first_q;
    assign cfg.clock_cycles = clock_cycles_q;
    assign cfg.enable_reset = enable_reset_q;

    // config writes and soft reset decode
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            mode_q         <= MODE_DISABLED;
            msb_first_q    <= 1'b0;
            clock_cycles_q <= 5'd0;
            enable_reset_q <= 1'b0;
            soft_rst       <= 1'b0;
        end
        else
        begin
            soft_rst <= bus_wr && (bus_add == ADDR_CTRL);
            if (bus_wr && bus_add == ADDR_MODE)
            begin
                mode_q      <= tlu_mode_t'(bus_data_in[1:0]);
                msb_first_q <= bus_data_in[2];
            end
            if (bus_wr && bus_add == ADDR_CONF)
            begin
                clock_cycles_q <= bus_data_in[4:0];
                enable_reset_q <= bus_data_in[5];
            end
        end
    end

    // registered read-back
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            bus_data_out <= '0;
            trig_num_buf <= '0;
        end
        else
        begin
            if (bus_add == ADDR_TRIG_NUM)
                trig_num_buf <= trig_number[WORD_WIDTH-1:8];  // keeps the upper bytes coherent
            case (bus_add)
                ADDR_CTRL:          bus_data_out <= VERSION;
                ADDR_MODE:          bus_data_out <= {5'd0, msb_first_q, mode_q};
                ADDR_CONF:          bus_data_out <= {2'd0, enable_reset_q, clock_cycles_q};
                ADDR_TRIG_NUM:      bus_data_out <= trig_number[7:0];
                ADDR_TRIG_NUM + 1:  bus_data_out <= trig_num_buf[15:8];
                ADDR_TRIG_NUM + 2:  bus_data_out <= trig_num_buf[23:16];
                ADDR_TRIG_NUM + 3:  bus_data_out <= trig_num_buf[31:24];
                ADDR_LOST:          bus_data_out <= lost_count;
                default:            bus_data_out <= '0;
            endcase
        end
    end

    // soft reset clears itself through the top level reset
    a_soft_rst_pulse: assert property (@(posedge BUS_CLK) soft_rst |=> !soft_rst);

endmodule

/* source/tlu_trig_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// selected trigger lines
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface tlu_trig_if ();

    logic trigger;       // synchronized level
    logic trigger_rise;  // one-cycle pulse
    logic reset_rise;    // one-cycle pulse, gated by enable_reset
    logic reset_level;

    modport source (output trigger, trigger_rise, reset_rise, reset_level);

    modport sink (input trigger, trigger_rise, reset_rise, reset_level);

endinterface

/* source/trigger_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// trigger word fifo
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module trigger_fifo import tlu_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic                  push,
    input  logic [WORD_WIDTH-1:0] word,
    input  logic                  read,
    output logic                  empty,
    output logic [WORD_WIDTH-1:0] data,
    output logic [7:0]            lost_count
);

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam logic [PW-1:0] LAST = PW'(FIFO_DEPTH - 1);

    logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [PW:0]           count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PW+1)'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = read && !empty;
    assign data    = mem[rd_ptr];  // first word falls through

    always_ff @(posedge BUS_CLK)
        if (do_push)
            mem[wr_ptr] <= word;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full && lost_count != 8'hff)
                lost_count <= lost_count + 8'd1;  // saturates
        end
    end

    a_no_pop_empty: assert property (@(posedge BUS_CLK) disable iff (RST) read |-> !empty);

endmodule

/* source/trigger_input.sv */
// ~~~~~~~~~~~~~~~~~~~~
// trigger input stage
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module trigger_input import tlu_pkg::*; (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic        rj45_trigger,
    input  logic        rj45_reset,
    input  logic        lemo_trigger,
    input  logic        lemo_reset,
    tlu_cfg_if.sink     cfg,
    output logic        rj45_enabled,
    tlu_trig_if.source  trig
);

    logic [SYNC_STAGES-1:0][3:0] sync_q;  // stage 0 is the newest
    logic [3:0] synced;
    logic       sel_trigger;
    logic       sel_reset;
    logic       trigger_prev;
    logic       reset_prev;

    // order is lemo reset, lemo trigger, rj45 reset, rj45 trigger
    always_ff @(posedge BUS_CLK)
        sync_q <= {sync_q[SYNC_STAGES-2:0], {lemo_reset, lemo_trigger, rj45_reset, rj45_trigger}};

    assign synced = sync_q[SYNC_STAGES-1];

    // unplugged rj45 reads both lines high
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || cfg.mode == MODE_DISABLED)
            rj45_enabled <= 1'b0;
        else if (!(synced[0] && synced[1]))
            rj45_enabled <= 1'b1;
    end

    assign sel_trigger = rj45_enabled ? synced[0] : synced[2];
    assign sel_reset   = rj45_enabled ? synced[1] : synced[3];

    assign trig.trigger     = sel_trigger;
    assign trig.reset_level = sel_reset;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trigger_prev      <= 1'b0;
            reset_prev        <= 1'b0;
            trig.trigger_rise <= 1'b0;
            trig.reset_rise   <= 1'b0;
        end
        else
        begin
            trigger_prev      <= sel_trigger;
            reset_prev        <= sel_reset;
            trig.trigger_rise <= sel_trigger && !trigger_prev;
            trig.reset_rise   <= sel_reset && !reset_prev && cfg.enable_reset;
        end
    end

endmodule

/* testbench/tb_tlu_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~
// tlu controller testbench
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_tlu_controller import tlu_pkg::*; ();

    localparam int MAX_CYCLES = 40000;  // about ten times the test length

    logic                  BUS_CLK;
    logic                  RST;
    logic [ADDR_WIDTH-1:0] BUS_ADD;
    logic [DATA_WIDTH-1:0] BUS_DATA_IN;
    logic                  BUS_WR;
    logic [DATA_WIDTH-1:0] BUS_DATA_OUT;
    logic                  FIFO_READ;
    logic                  FIFO_EMPTY;
    logic [WORD_WIDTH-1:0] FIFO_DATA;
    logic                  RJ45_TRIGGER;
    logic                  LEMO_TRIGGER;
    logic                  RJ45_RESET;
    logic                  LEMO_RESET;
    logic                  RJ45_ENABLED;
    logic                  TLU_BUSY;
    logic                  TLU_CLOCK;

    logic [31:0] exp_q [$];      // expected fifo words in order
    logic [31:0] cnt_model;      // mirror of the trigger counter
    bit          use_lemo;
    bit          drain_en;       // compare process pops the fifo
    int          n_errors;
    int          n_checks;
    int          n_list [3] = '{8, 15, 0};

    tlu_controller u_dut (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_WR       (BUS_WR),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .FIFO_READ    (FIFO_READ),
        .FIFO_EMPTY   (FIFO_EMPTY),
        .FIFO_DATA    (FIFO_DATA),
        .RJ45_TRIGGER (RJ45_TRIGGER),
        .LEMO_TRIGGER (LEMO_TRIGGER),
        .RJ45_RESET   (RJ45_RESET),
        .LEMO_RESET   (LEMO_RESET),
        .RJ45_ENABLED (RJ45_ENABLED),
        .TLU_BUSY     (TLU_BUSY),
        .TLU_CLOCK    (TLU_CLOCK)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            n_errors++;
        end
    endtask

    // word the tlu should leave in the fifo
    // the tlu sends bit k of sent on pulse k
    function automatic logic [31:0] expected_word(input tlu_mode_t mode, input logic [31:0] count,
                                                  input logic [31:0] sent, input int n,
                                                  input bit msb_first);
        logic [31:0] value;
        int          nbits;
        nbits = (n == 0) ? 32 : n;
        value = count;
        if (mode == MODE_DATA_HANDSHAKE)
        begin
            value = '0;
            for (int k = 0; k < nbits; k++)
            begin
                if (msb_first)
                    value[nbits-1-k] = sent[k];  // first bit is the msb
                else
                    value[k] = sent[k];
            end
        end
        return {1'b1, value[30:0]};
    endfunction

    task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= addr;
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        @(posedge BUS_CLK);
        @(negedge BUS_CLK);  // output registered one cycle after the address
        data = BUS_DATA_OUT;
    endtask

    task automatic drive_trigger(input logic v);
        if (use_lemo)
            LEMO_TRIGGER <= v;
        else
            RJ45_TRIGGER <= v;
    endtask

    // plays the tlu side of one trigger and queues its expected word if kept
    task automatic send_trigger(input tlu_mode_t mode, input int n, input bit msb, input bit keep);
        logic [31:0] sent;
        int          pulses;
        logic        prev;
        sent = $urandom();
        if (keep)
            exp_q.push_back(expected_word(mode, cnt_model, sent, n, msb));
        cnt_model++;
        @(posedge BUS_CLK);
        drive_trigger(1'b1);
        if (mode == MODE_NO_HANDSHAKE)
        begin
            repeat (4) @(posedge BUS_CLK);
            drive_trigger(1'b0);
            repeat (8) @(posedge BUS_CLK);
        end
        else
        begin
            while (!TLU_BUSY)
                @(posedge BUS_CLK);
            repeat (3)
            begin
                @(posedge BUS_CLK);
                check("TLU_BUSY", TLU_BUSY, 1);  // held while trigger is high
            end
            drive_trigger(1'b0);
            pulses = 0;
            prev   = 1'b0;
            while (TLU_BUSY)
            begin
                @(posedge BUS_CLK);
                if (TLU_CLOCK && !prev)
                begin
                    if (pulses < 32)
                        drive_trigger(sent[pulses]);
                    pulses++;
                end
                prev = TLU_CLOCK;
            end
            check("TLU_CLOCK pulses", pulses,
                  (mode == MODE_DATA_HANDSHAKE) ? ((n == 0) ? 32 : n) : 0);
            drive_trigger(1'b0);
            repeat (6) @(posedge BUS_CLK);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(posedge BUS_CLK);
    endtask

    // compare process pops one word and checks it
    initial
    begin
        FIFO_READ = 1'b0;
        forever
        begin
            @(posedge BUS_CLK);
            if (FIFO_READ)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("unexpected FIFO word 0x%08h while none was expected", FIFO_DATA);
                    n_errors++;
                end
                else
                    check("FIFO_DATA", FIFO_DATA, exp_q.pop_front());
                FIFO_READ <= 1'b0;
            end
            else if (drain_en && !FIFO_EMPTY && !RST)
                FIFO_READ <= 1'b1;
        end
    end

    initial
    begin
        repeat (MAX_CYCLES) @(posedge BUS_CLK);
        n_errors++;
        $display("timeout, the test did not finish within %0d cycles", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        logic [7:0]  rd;
        logic [31:0] num;
        logic [31:0] first_cnt;
        void'($urandom(32'h1874_1389));
        RST          = 1'b1;
        BUS_ADD      = '0;
        BUS_DATA_IN  = '0;
        BUS_WR       = 1'b0;
        RJ45_TRIGGER = 1'b1;  // rj45 unplugged
        RJ45_RESET   = 1'b1;
        LEMO_TRIGGER = 1'b0;
        LEMO_RESET   = 1'b0;
        use_lemo     = 1'b1;
        drain_en     = 1'b1;
        cnt_model    = '0;
        n_errors     = 0;
        n_checks     = 0;
        repeat (3) @(posedge BUS_CLK);
        RST <= 1'b0;

        // register read-back and idle outputs
        bus_read(ADDR_CTRL, rd);
        check("VERSION", rd, VERSION);
        bus_write(ADDR_MODE, 8'h06);
        bus_read(ADDR_MODE, rd);
        check("mode register", rd, 8'h06);
        bus_write(ADDR_CONF, 8'h2f);
        bus_read(ADDR_CONF, rd);
        check("conf register", rd, 8'h2f);
        @(posedge BUS_CLK);
        check("TLU_BUSY", TLU_BUSY, 0);
        check("TLU_CLOCK", TLU_CLOCK, 0);
        check("RJ45_ENABLED", RJ45_ENABLED, 0);
        check("FIFO_EMPTY", FIFO_EMPTY, 1);

        // no handshake on lemo
        bus_write(ADDR_CONF, 8'h00);
        bus_write(ADDR_MODE, {6'd0, MODE_NO_HANDSHAKE});
        repeat (5) send_trigger(MODE_NO_HANDSHAKE, 0, 1'b0, 1'b1);
        wait_drained();
        check("RJ45_ENABLED", RJ45_ENABLED, 0);

        // simple handshake on rj45, then a tlu reset
        @(posedge BUS_CLK);
        RJ45_TRIGGER <= 1'b0;
        RJ45_RESET   <= 1'b0;
        use_lemo = 1'b0;
        bus_write(ADDR_CONF, 8'h20);
        bus_write(ADDR_MODE, {6'd0, MODE_SIMPLE_HANDSHAKE});
        repeat (10) @(posedge BUS_CLK);
        check("RJ45_ENABLED", RJ45_ENABLED, 1);
        repeat (3) send_trigger(MODE_SIMPLE_HANDSHAKE, 0, 1'b0, 1'b1);
        wait_drained();
        RJ45_RESET <= 1'b1;
        repeat (3) @(posedge BUS_CLK);
        RJ45_RESET <= 1'b0;
        repeat (6) @(posedge BUS_CLK);
        cnt_model = '0;
        repeat (2) send_trigger(MODE_SIMPLE_HANDSHAKE, 0, 1'b0, 1'b1);
        wait_drained();

        // data handshake, all lengths and both orders
        foreach (n_list[i])
        begin
            for (int msb = 0; msb < 2; msb++)
            begin
                bus_write(ADDR_CONF, 8'(n_list[i]));
                bus_write(ADDR_MODE, {5'd0, msb[0], MODE_DATA_HANDSHAKE});
                repeat (2) send_trigger(MODE_DATA_HANDSHAKE, n_list[i], msb[0], 1'b1);
                wait_drained();
            end
        end

        // overflow without reading
        bus_write(ADDR_MODE, {6'd0, MODE_NO_HANDSHAKE});
        drain_en  = 1'b0;
        first_cnt = cnt_model;
        for (int i = 0; i < 12; i++)
            send_trigger(MODE_NO_HANDSHAKE, 0, 1'b0, i < 8);
        bus_read(ADDR_LOST, rd);
        check("lost count", rd, 8'd4);
        for (int b = 0; b < 4; b++)
        begin
            bus_read(ADDR_TRIG_NUM + 16'(b), rd);
            num[8*b +: 8] = rd;
        end
        check("trigger number", num, first_cnt + 32'd11);
        drain_en = 1'b1;
        wait_drained();
        repeat (4) @(posedge BUS_CLK);
        check("FIFO_EMPTY", FIFO_EMPTY, 1);  // only eight were kept
        @(negedge BUS_CLK);
        drain_en = 1'b0;
        repeat (2) send_trigger(MODE_NO_HANDSHAKE, 0, 1'b0, 1'b0);
        check("FIFO_EMPTY", FIFO_EMPTY, 0);
        bus_write(ADDR_CTRL, 8'h00);
        cnt_model = '0;
        bus_read(ADDR_LOST, rd);
        check("lost count", rd, 8'd0);
        check("FIFO_EMPTY", FIFO_EMPTY, 1);
        bus_read(ADDR_MODE, rd);
        check("mode register", rd, 8'h00);

        wait_drained();
        repeat (4) @(posedge BUS_CLK);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
